//--- sim.f
+incdir+hw
hw/mem_pkg.sv
hw/clint.sv
hw/icache.sv
hw/mem_xbar.sv
hw/mem_subsys.sv
test/mem_checker.sv
test/mem_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module mem_subsys_tb -o mem_subsys_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/mem_subsys_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1

//--- test/mem_subsys_tb.sv
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_subsys_tb;

	import mem_pkg::*;

	localparam int kind_fetch = 0;
	localparam int kind_load  = 1;
	localparam int kind_write = 2;
	localparam int kind_both  = 3;

	logic clock = 1'b0;
	logic reset = 1'b1;

	logic [31:0] ifu_araddr;
	logic ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
	logic [31:0] ifu_rdata;
	resp_t ifu_rresp;
	logic [31:0] lsu_araddr, lsu_awaddr;
	logic [2:0] lsu_arsize, lsu_awsize;
	logic lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
	logic [63:0] lsu_rdata, lsu_wdata;
	resp_t lsu_rresp, lsu_bresp;
	logic lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
	logic [7:0] lsu_wstrb;
	logic [31:0] soc_araddr, soc_awaddr;
	logic [2:0] soc_arsize, soc_awsize;
	logic soc_arvalid, soc_arready, soc_rvalid, soc_rready;
	logic [63:0] soc_rdata, soc_wdata;
	resp_t soc_rresp, soc_bresp;
	logic soc_awvalid, soc_awready, soc_wvalid, soc_wready, soc_bvalid, soc_bready;
	logic [7:0] soc_wstrb;

	mem_subsys mem_subsys_inst (.*);

	mem_checker checker_inst (.*);

	always #2 clock = ~clock;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// SoC memory model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic [63:0] mem [logic [28:0]];
	logic [31:0] rd_addr, ar_addr_s, aw_addr_s;
	logic [63:0] w_data_s;
	logic [7:0] w_strb_s;
	logic ar_fire, r_fire, aw_fire, b_fire;
	int lat = 0;

	// a location never written holds its aligned address xor a pattern.
	function automatic logic [63:0] fresh_word(input logic [31:0] addr);
		return {32'h0, {addr[31:3], 3'b000} ^ 32'h5a5a5a5a};
	endfunction

	function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
			input logic [7:0] strb);
		logic [63:0] res;
		res = old;
		for (int i = 0; i < 8; i++) begin
			if (strb[i]) begin
				res[i*8 +: 8] = data[i*8 +: 8];
			end
		end
		return res;
	endfunction

	always @(posedge clock) begin
		ar_fire = soc_arvalid && soc_arready;
		r_fire = soc_rvalid && soc_rready;
		aw_fire = soc_awvalid && soc_awready && soc_wvalid && soc_wready;
		b_fire = soc_bvalid && soc_bready;
		ar_addr_s = soc_araddr;
		aw_addr_s = soc_awaddr;
		w_data_s = soc_wdata;
		w_strb_s = soc_wstrb;
		#1;
		if (reset) begin
			soc_arready = 1'b1;
			soc_rvalid = 1'b0;
			soc_bvalid = 1'b0;
			lat = 0;
		end else begin
			if (r_fire) begin
				soc_rvalid = 1'b0;
				soc_arready = 1'b1;
			end
			if (ar_fire) begin
				rd_addr = ar_addr_s;
				soc_arready = 1'b0;
				lat = $urandom_range(1, 4);
			end else if (lat != 0) begin
				lat = lat - 1;
				if (lat == 0) begin
					soc_rvalid = 1'b1;
					if (rd_addr >= 32'h3000_0000) begin
						soc_rdata = '0;
						soc_rresp = resp_slverr;
					end else begin
						soc_rdata = mem.exists(rd_addr[31:3]) ? mem[rd_addr[31:3]]
							: fresh_word(rd_addr);
						soc_rresp = resp_okay;
					end
				end
			end
			if (b_fire) begin
				soc_bvalid = 1'b0;
			end
			if (aw_fire) begin
				mem[aw_addr_s[31:3]] = merge_bytes(mem.exists(aw_addr_s[31:3])
					? mem[aw_addr_s[31:3]] : fresh_word(aw_addr_s), w_data_s, w_strb_s);
				soc_bvalid = 1'b1;
				soc_bresp = (aw_addr_s >= 32'h3000_0000) ? resp_slverr : resp_okay;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus table and core-side drivers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	string row_name[$];
	int row_kind[$], row_delta[$], row_mode[$];
	logic [31:0] row_addr[$];
	logic [2:0] row_size[$];
	logic [63:0] row_wdata[$], row_exp[$];
	logic [7:0] row_strb[$];
	resp_t row_resp[$];
	int cycle_limit = 1000;
	int cycle_count = 0;

	task add_row(input string name, input int kind, input logic [31:0] addr,
			input logic [2:0] size, input logic [63:0] wdata, input logic [7:0] strb,
			input logic [63:0] exp, input resp_t resp, input int delta, input int mode);
		row_name.push_back(name);
		row_kind.push_back(kind);
		row_addr.push_back(addr);
		row_size.push_back(size);
		row_wdata.push_back(wdata);
		row_strb.push_back(strb);
		row_exp.push_back(exp);
		row_resp.push_back(resp);
		row_delta.push_back(delta);
		row_mode.push_back(mode);
	endtask

	task do_fetch(input logic [31:0] addr);
		int hold;
		ifu_araddr = addr;
		ifu_arvalid = 1'b1;
		@(posedge clock);
		while (!ifu_arready) @(posedge clock);
		#1 ifu_arvalid = 1'b0;
		hold = $urandom_range(0, 3);
		repeat (hold) @(posedge clock);
		if (hold != 0) #1;
		ifu_rready = 1'b1;
		@(posedge clock);
		while (!ifu_rvalid) @(posedge clock);
		#1 ifu_rready = 1'b0;
	endtask

	task do_load(input logic [31:0] addr, input logic [2:0] size);
		int hold;
		lsu_araddr = addr;
		lsu_arsize = size;
		lsu_arvalid = 1'b1;
		@(posedge clock);
		while (!lsu_arready) @(posedge clock);
		#1 lsu_arvalid = 1'b0;
		hold = $urandom_range(0, 3);
		repeat (hold) @(posedge clock);
		if (hold != 0) #1;
		lsu_rready = 1'b1;
		@(posedge clock);
		while (!lsu_rvalid) @(posedge clock);
		#1 lsu_rready = 1'b0;
	endtask

	task do_write(input logic [31:0] addr, input logic [2:0] size, input logic [63:0] data,
			input logic [7:0] strb);
		int hold;
		lsu_awaddr = addr;
		lsu_awsize = size;
		lsu_wdata = data;
		lsu_wstrb = strb;
		lsu_awvalid = 1'b1;
		lsu_wvalid = 1'b1;
		@(posedge clock);
		while (!(lsu_awready && lsu_wready)) @(posedge clock);
		#1 lsu_awvalid = 1'b0;
		lsu_wvalid = 1'b0;
		hold = $urandom_range(0, 3);
		repeat (hold) @(posedge clock);
		if (hold != 0) #1;
		lsu_bready = 1'b1;
		@(posedge clock);
		while (!lsu_bvalid) @(posedge clock);
		#1 lsu_bready = 1'b0;
	endtask

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the run went past %0d cycles", cycle_limit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'hb3cc7c0f));
		{ifu_araddr, ifu_arvalid, ifu_rready} = '0;
		{lsu_araddr, lsu_arsize, lsu_arvalid, lsu_rready} = '0;
		{lsu_awaddr, lsu_awsize, lsu_awvalid, lsu_wdata, lsu_wstrb, lsu_wvalid} = '0;
		lsu_bready = 1'b0;
		soc_arready = 1'b1;
		soc_rvalid = 1'b0;
		soc_rdata = '0;
		soc_rresp = resp_okay;
		soc_awready = 1'b1;
		soc_wready = 1'b1;
		soc_bvalid = 1'b0;
		soc_bresp = resp_okay;

		add_row("fetch_miss", kind_fetch, 32'h0000_1000, 3'd2, 0, 0,
			fresh_word(32'h0000_1000), resp_okay, 1, 0);
		add_row("fetch_hit", kind_fetch, 32'h0000_1000, 3'd2, 0, 0,
			fresh_word(32'h0000_1000), resp_okay, 0, 0);
		add_row("sram_fetch_a", kind_fetch, 32'h0f00_0010, 3'd2, 0, 0,
			fresh_word(32'h0f00_0010), resp_okay, 1, 0);
		add_row("sram_fetch_b", kind_fetch, 32'h0f00_0010, 3'd2, 0, 0,
			fresh_word(32'h0f00_0010), resp_okay, 1, 0);
		add_row("write_partial", kind_write, 32'h0000_2008, 3'd3, 64'h1122_3344_5566_7788,
			8'h3c, 0, resp_okay, 0, 0);
		add_row("read_back", kind_load, 32'h0000_2008, 3'd3, 0, 0,
			merge_bytes(fresh_word(32'h0000_2008), 64'h1122_3344_5566_7788, 8'h3c),
			resp_okay, 1, 0);
		add_row("timer_first", kind_load, 32'h0200_0000, 3'd2, 0, 0, 0, resp_okay, 0, 1);
		add_row("timer_later", kind_load, 32'h0200_0000, 3'd2, 0, 0, 0, resp_okay, 0, 2);
		add_row("timer_bad_offset", kind_load, 32'h0200_0008, 3'd2, 0, 0, 0,
			resp_decerr, 0, 0);
		add_row("error_fetch_a", kind_fetch, 32'h3000_0000, 3'd2, 0, 0, 0, resp_slverr, 1, 0);
		add_row("error_fetch_b", kind_fetch, 32'h3000_0000, 3'd2, 0, 0, 0, resp_slverr, 1, 0);
		add_row("fetch_wins", kind_both, 32'h0000_3000, 3'd3, 0, 0,
			fresh_word(32'h0000_3000), resp_okay, 2, 0);
		cycle_limit = 40 * row_name.size();

		repeat (3) @(posedge clock);
		#1 reset = 1'b0;
		@(posedge clock);
		#1;

		foreach (row_name[i]) begin
			checker_inst.start_test();
			case (row_kind[i])
				kind_fetch: do_fetch(row_addr[i]);
				kind_load: do_load(row_addr[i], row_size[i]);
				kind_write: do_write(row_addr[i], row_size[i], row_wdata[i], row_strb[i]);
				default: begin
					fork
						do_fetch(row_addr[i]);
						do_load(row_addr[i], row_size[i]);
					join
				end
			endcase
			checker_inst.end_test(row_name[i], row_kind[i], row_exp[i], row_resp[i],
				row_size[i], row_delta[i], row_mode[i]);
		end

		$display("tests %0d, passed %0d, failed %0d", row_name.size(),
			checker_inst.pass_count, checker_inst.fail_count);
		if (checker_inst.fail_count == 0 && checker_inst.pass_count == row_name.size()) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- test/mem_checker.sv
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_checker (
	input logic                clock,
	input logic                reset,
	input logic                ifu_rvalid,
	input logic                ifu_rready,
	input logic [`IDATA_W-1:0] ifu_rdata,
	input mem_pkg::resp_t      ifu_rresp,
	input logic                lsu_rvalid,
	input logic                lsu_rready,
	input logic [`DATA_W-1:0]  lsu_rdata,
	input mem_pkg::resp_t      lsu_rresp,
	input logic                lsu_bvalid,
	input logic                lsu_bready,
	input mem_pkg::resp_t      lsu_bresp,
	input logic                soc_arvalid,
	input logic                soc_arready,
	input logic [`SIZE_W-1:0]  soc_arsize,
	input logic                soc_awvalid,
	input logic                soc_awready,
	input logic [`SIZE_W-1:0]  soc_awsize
);

	import mem_pkg::*;

	localparam int kind_fetch = 0;
	localparam int kind_load  = 1;
	localparam int kind_write = 2;
	localparam int kind_both  = 3;

	// a fetch reads one 32-bit word, size code 2.
	localparam logic [`SIZE_W-1:0] fetch_size = 3'd2;

	int ar_count = 0;
	int ar_mark = 0;
	int seq = 0;
	int ifu_seq;
	int lsu_seq;
	int pass_count = 0;
	int fail_count = 0;
	logic got_ifu = 1'b0;
	logic got_lsu = 1'b0;
	logic got_b = 1'b0;
	logic both_replies = 1'b0;
	logic [`IDATA_W-1:0] ifu_data;
	logic [`DATA_W-1:0]  lsu_data;
	resp_t ifu_resp;
	resp_t lsu_resp;
	resp_t b_resp;
	logic [`DATA_W-1:0] timer_mark = '0;
	logic [`SIZE_W-1:0] ar_size_q[$];
	logic ar_early_q[$];
	logic [`SIZE_W-1:0] aw_size;

	// handshakes are sampled at the edge, before the DUT updates.
	always @(posedge clock) begin
		if (!reset) begin
			if (soc_arvalid && soc_arready) begin
				ar_count = ar_count + 1;
				ar_size_q.push_back(soc_arsize);
				ar_early_q.push_back(!got_ifu);
			end
			if (ifu_rvalid && lsu_rvalid) begin
				both_replies = 1'b1;
			end
			if (ifu_rvalid && ifu_rready) begin
				got_ifu = 1'b1;
				ifu_data = ifu_rdata;
				ifu_resp = ifu_rresp;
				ifu_seq = seq;
				seq = seq + 1;
			end
			if (lsu_rvalid && lsu_rready) begin
				got_lsu = 1'b1;
				lsu_data = lsu_rdata;
				lsu_resp = lsu_rresp;
				lsu_seq = seq;
				seq = seq + 1;
			end
			if (lsu_bvalid && lsu_bready) begin
				got_b = 1'b1;
				b_resp = lsu_bresp;
			end
			if (soc_awvalid && soc_awready) begin
				aw_size = soc_awsize;
			end
		end
	end

	task start_test();
		ar_mark = ar_count;
		got_ifu = 1'b0;
		got_lsu = 1'b0;
		got_b = 1'b0;
		both_replies = 1'b0;
		ar_size_q.delete();
		ar_early_q.delete();
	endtask

	task check_value(input string name, input string field, input logic [63:0] exp,
			input logic [63:0] act, inout logic ok);
		if (ok && exp !== act) begin
			$display("ERR %s %s expected %h actual %h", name, field, exp, act);
			ok = 1'b0;
		end
	endtask

	task end_test(input string name, input int kind, input logic [63:0] exp_data,
			input resp_t exp_resp, input logic [`SIZE_W-1:0] exp_size,
			input int exp_delta, input int mode);
		logic ok;
		logic [`SIZE_W-1:0] want_size;
		ok = 1'b1;
		if ((kind == kind_fetch || kind == kind_both) && !got_ifu) begin
			$display("%s: the fetch reply never arrived", name);
			ok = 1'b0;
		end
		if ((kind == kind_load || kind == kind_both) && ok && !got_lsu) begin
			$display("%s: the load reply never arrived", name);
			ok = 1'b0;
		end
		if (kind == kind_write && !got_b) begin
			$display("%s: the write response never arrived", name);
			ok = 1'b0;
		end
		if (kind == kind_both && ok && ifu_seq > lsu_seq) begin
			$display("%s: the load was answered before the fetch", name);
			ok = 1'b0;
		end
		if (ok && both_replies) begin
			$display("%s: the fetch and load replies were valid in the same cycle", name);
			ok = 1'b0;
		end
		if (kind == kind_fetch || kind == kind_both) begin
			check_value(name, "fetch data", {32'h0, exp_data[31:0]}, {32'h0, ifu_data}, ok);
			check_value(name, "fetch resp", 64'(exp_resp), 64'(ifu_resp), ok);
		end
		if (kind == kind_load || kind == kind_both) begin
			if (mode == 0) begin
				check_value(name, "load data", exp_data, lsu_data, ok);
			end else if (mode == 2 && ok && !(lsu_data > timer_mark)) begin
				$display("ERR %s load data expected above %h actual %h",
					name, timer_mark, lsu_data);
				ok = 1'b0;
			end
			check_value(name, "load resp", 64'(exp_resp), 64'(lsu_resp), ok);
			timer_mark = lsu_data;
		end
		if (kind == kind_write) begin
			check_value(name, "write resp", 64'(exp_resp), 64'(b_resp), ok);
			check_value(name, "soc write size", 64'(exp_size), 64'(aw_size), ok);
		end
		check_value(name, "soc reads", 64'(exp_delta), 64'(ar_count - ar_mark), ok);
		foreach (ar_size_q[i]) begin
			if (kind == kind_fetch || (kind == kind_both && ar_early_q[i])) begin
				want_size = fetch_size;
			end else begin
				want_size = exp_size;
			end
			check_value(name, "soc read size", 64'(want_size), 64'(ar_size_q[i]), ok);
		end
		if (ok) begin
			pass_count = pass_count + 1;
			$display("ok  %s", name);
		end else begin
			fail_count = fail_count + 1;
		end
	endtask

endmodule

//--- hw/mem_subsys.sv
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_subsys (
	input  logic                clock,
	input  logic                reset,

	input  logic [`ADDR_W-1:0]  ifu_araddr,
	input  logic                ifu_arvalid,
	output logic                ifu_arready,
	output logic [`IDATA_W-1:0] ifu_rdata,
	output mem_pkg::resp_t      ifu_rresp,
	output logic                ifu_rvalid,
	input  logic                ifu_rready,

	input  logic [`ADDR_W-1:0]  lsu_araddr,
	input  logic [`SIZE_W-1:0]  lsu_arsize,
	input  logic                lsu_arvalid,
	output logic                lsu_arready,
	output logic [`DATA_W-1:0]  lsu_rdata,
	output mem_pkg::resp_t      lsu_rresp,
	output logic                lsu_rvalid,
	input  logic                lsu_rready,
	input  logic [`ADDR_W-1:0]  lsu_awaddr,
	input  logic [`SIZE_W-1:0]  lsu_awsize,
	input  logic                lsu_awvalid,
	output logic                lsu_awready,
	input  logic [`DATA_W-1:0]  lsu_wdata,
	input  logic [`STRB_W-1:0]  lsu_wstrb,
	input  logic                lsu_wvalid,
	output logic                lsu_wready,
	output mem_pkg::resp_t      lsu_bresp,
	output logic                lsu_bvalid,
	input  logic                lsu_bready,

	output logic [`ADDR_W-1:0]  soc_araddr,
	output logic [`SIZE_W-1:0]  soc_arsize,
	output logic                soc_arvalid,
	input  logic                soc_arready,
	input  logic [`DATA_W-1:0]  soc_rdata,
	input  mem_pkg::resp_t      soc_rresp,
	input  logic                soc_rvalid,
	output logic                soc_rready,
	output logic [`ADDR_W-1:0]  soc_awaddr,
	output logic [`SIZE_W-1:0]  soc_awsize,
	output logic                soc_awvalid,
	input  logic                soc_awready,
	output logic [`DATA_W-1:0]  soc_wdata,
	output logic [`STRB_W-1:0]  soc_wstrb,
	output logic                soc_wvalid,
	input  logic                soc_wready,
	input  mem_pkg::resp_t      soc_bresp,
	input  logic                soc_bvalid,
	output logic                soc_bready
);

	import mem_pkg::*;

	logic [`ADDR_W-1:0]  cache_rd_addr;
	logic                cache_rd_valid;
	logic                cache_rd_resp_valid;
	logic                cache_rd_hit;
	logic [`IDATA_W-1:0] cache_rd_data;
	logic [`ADDR_W-1:0]  cache_fill_addr;
	logic [`IDATA_W-1:0] cache_fill_data;
	logic                cache_fill_valid;

	logic [`ADDR_W-1:0]  clint_araddr;
	logic                clint_arvalid;
	logic                clint_rvalid;
	logic [`IDATA_W-1:0] clint_rdata;
	resp_t               clint_rresp;

	// the crossbar port names match the top level and the wires above.
	mem_xbar mem_xbar_inst (.*);

	icache icache_inst (
		.clock         (clock),
		.reset         (reset),
		.rd_addr       (cache_rd_addr),
		.rd_valid      (cache_rd_valid),
		.rd_resp_valid (cache_rd_resp_valid),
		.rd_hit        (cache_rd_hit),
		.rd_data       (cache_rd_data),
		.fill_addr     (cache_fill_addr),
		.fill_data     (cache_fill_data),
		.fill_valid    (cache_fill_valid)
	);

	clint clint_inst (
		.clock   (clock),
		.reset   (reset),
		.araddr  (clint_araddr),
		.arvalid (clint_arvalid),
		.rvalid  (clint_rvalid),
		.rdata   (clint_rdata),
		.rresp   (clint_rresp)
	);

endmodule

//--- hw/mem_xbar.sv
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_xbar (
	input  logic                clock,
	input  logic                reset,

	input  logic [`ADDR_W-1:0]  ifu_araddr,
	input  logic                ifu_arvalid,
	output logic                ifu_arready,
	output logic [`IDATA_W-1:0] ifu_rdata,
	output mem_pkg::resp_t      ifu_rresp,
	output logic                ifu_rvalid,
	input  logic                ifu_rready,

	input  logic [`ADDR_W-1:0]  lsu_araddr,
	input  logic [`SIZE_W-1:0]  lsu_arsize,
	input  logic                lsu_arvalid,
	output logic                lsu_arready,
	output logic [`DATA_W-1:0]  lsu_rdata,
	output mem_pkg::resp_t      lsu_rresp,
	output logic                lsu_rvalid,
	input  logic                lsu_rready,
	input  logic [`ADDR_W-1:0]  lsu_awaddr,
	input  logic [`SIZE_W-1:0]  lsu_awsize,
	input  logic                lsu_awvalid,
	output logic                lsu_awready,
	input  logic [`DATA_W-1:0]  lsu_wdata,
	input  logic [`STRB_W-1:0]  lsu_wstrb,
	input  logic                lsu_wvalid,
	output logic                lsu_wready,
	output mem_pkg::resp_t      lsu_bresp,
	output logic                lsu_bvalid,
	input  logic                lsu_bready,

	output logic [`ADDR_W-1:0]  soc_araddr,
	output logic [`SIZE_W-1:0]  soc_arsize,
	output logic                soc_arvalid,
	input  logic                soc_arready,
	input  logic [`DATA_W-1:0]  soc_rdata,
	input  mem_pkg::resp_t      soc_rresp,
	input  logic                soc_rvalid,
	output logic                soc_rready,
	output logic [`ADDR_W-1:0]  soc_awaddr,
	output logic [`SIZE_W-1:0]  soc_awsize,
	output logic                soc_awvalid,
	input  logic                soc_awready,
	output logic [`DATA_W-1:0]  soc_wdata,
	output logic [`STRB_W-1:0]  soc_wstrb,
	output logic                soc_wvalid,
	input  logic                soc_wready,
	input  mem_pkg::resp_t      soc_bresp,
	input  logic                soc_bvalid,
	output logic                soc_bready,

	output logic [`ADDR_W-1:0]  cache_rd_addr,
	output logic                cache_rd_valid,
	input  logic                cache_rd_resp_valid,
	input  logic                cache_rd_hit,
	input  logic [`IDATA_W-1:0] cache_rd_data,
	output logic [`ADDR_W-1:0]  cache_fill_addr,
	output logic [`IDATA_W-1:0] cache_fill_data,
	output logic                cache_fill_valid,

	output logic [`ADDR_W-1:0]  clint_araddr,
	output logic                clint_arvalid,
	input  logic                clint_rvalid,
	input  logic [`IDATA_W-1:0] clint_rdata,
	input  mem_pkg::resp_t      clint_rresp
);

	import mem_pkg::*;

	xbar_state_t        state;
	xbar_state_t        state_next;
	logic [`ADDR_W-1:0] ifu_addr;
	logic               ifu_uncached;
	logic [`ADDR_W-1:0] lsu_addr;
	logic [`SIZE_W-1:0] lsu_size;
	logic               lsu_decoded;
	logic               lsu_to_clint;
	logic               req_valid;
	logic [`DATA_W-1:0] reply_data;
	resp_t              reply_resp;

	logic ifu_ar_fire;
	logic lsu_ar_fire;
	logic soc_ar_fire;
	logic soc_r_fire;
	logic ifu_in_sram;
	logic lsu_in_clint;
	logic lsu_decode;

	assign ifu_ar_fire = ifu_arvalid && ifu_arready;
	assign lsu_ar_fire = lsu_arvalid && lsu_arready;
	assign soc_ar_fire = soc_arvalid && soc_arready;
	assign soc_r_fire  = soc_rvalid && soc_rready;

	// fetch is decoded on the live address, load on the latched one a cycle later.
	assign ifu_in_sram  = (ifu_araddr >= `SRAM_BASE) && (ifu_araddr <= `SRAM_LIMIT);
	assign lsu_in_clint = (lsu_addr >= `CLINT_BASE) && (lsu_addr <= `CLINT_LIMIT);
	assign lsu_decode   = (state == st_lsu_read) && !lsu_decoded;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read state machine
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (ifu_ar_fire) begin
					if (ifu_in_sram) begin
						state_next = st_ifu_soc;
					end else begin
						state_next = st_ifu_cache;
					end
				end else if (lsu_ar_fire) begin
					state_next = st_lsu_read;
				end
			end
			st_ifu_cache: begin
				if (cache_rd_resp_valid) begin
					if (cache_rd_hit) begin
						state_next = st_ifu_reply;
					end else begin
						state_next = st_ifu_soc;
					end
				end
			end
			st_ifu_soc: begin
				// an error or an SRAM word is handed back without a fill.
				if (soc_r_fire) begin
					if (ifu_uncached || soc_rresp != resp_okay) begin
						state_next = st_ifu_reply;
					end else begin
						state_next = st_cache_fill;
					end
				end
			end
			st_cache_fill: begin
				state_next = st_ifu_reply;
			end
			st_ifu_reply: begin
				if (ifu_rready) begin
					state_next = st_idle;
				end
			end
			st_lsu_read: begin
				if (soc_r_fire || clint_rvalid) begin
					state_next = st_lsu_reply;
				end
			end
			st_lsu_reply: begin
				if (lsu_rready) begin
					state_next = st_idle;
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= st_idle;
			ifu_arready <= 1'b0;
			lsu_arready <= 1'b0;
			req_valid   <= 1'b0;
			lsu_decoded <= 1'b0;
		end else begin
			state <= state_next;
			// arready is a one-cycle pulse, and the fetch wins when both wait.
			ifu_arready <= (state == st_idle) && ifu_arvalid && !ifu_arready && !lsu_arready;
			lsu_arready <= (state == st_idle) && lsu_arvalid && !ifu_arvalid
				&& !ifu_arready && !lsu_arready;
			if (cache_rd_valid || clint_arvalid || soc_ar_fire) begin
				req_valid <= 1'b0;
			end
			if (ifu_ar_fire || lsu_decode) begin
				req_valid <= 1'b1;
			end
			if (state == st_ifu_cache && cache_rd_resp_valid && !cache_rd_hit) begin
				req_valid <= 1'b1;
			end
			if (lsu_ar_fire) begin
				lsu_decoded <= 1'b0;
			end else if (lsu_decode) begin
				lsu_decoded <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ifu_ar_fire) begin
			ifu_addr     <= ifu_araddr;
			ifu_uncached <= ifu_in_sram;
		end
		if (lsu_ar_fire) begin
			lsu_addr <= lsu_araddr;
			lsu_size <= lsu_arsize;
		end
		if (lsu_decode) begin
			lsu_to_clint <= lsu_in_clint;
		end
		if (state == st_ifu_cache && cache_rd_resp_valid && cache_rd_hit) begin
			reply_data <= {{(`DATA_W-`IDATA_W){1'b0}}, cache_rd_data};
			reply_resp <= resp_okay;
		end
		if (soc_r_fire) begin
			reply_data <= soc_rdata;
			reply_resp <= soc_rresp;
		end
		if (state == st_lsu_read && clint_rvalid) begin
			reply_data <= {{(`DATA_W-`IDATA_W){1'b0}}, clint_rdata};
			reply_resp <= clint_rresp;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// downstream requests and replies
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign cache_rd_valid   = (state == st_ifu_cache) && req_valid;
	assign cache_rd_addr    = ifu_addr;
	assign cache_fill_valid = (state == st_cache_fill);
	assign cache_fill_addr  = ifu_addr;
	assign cache_fill_data  = reply_data[`IDATA_W-1:0];

	assign clint_arvalid = (state == st_lsu_read) && req_valid && lsu_to_clint;
	assign clint_araddr  = lsu_addr;

	// req_valid holds through a stalled soc_arready, the address comes from the latches.
	assign soc_arvalid = req_valid
		&& ((state == st_ifu_soc) || (state == st_lsu_read && !lsu_to_clint));
	assign soc_araddr  = (state == st_lsu_read) ? lsu_addr : ifu_addr;
	assign soc_arsize  = (state == st_lsu_read) ? lsu_size : `FETCH_SIZE;
	assign soc_rready  = (state == st_ifu_soc)
		|| (state == st_lsu_read && lsu_decoded && !lsu_to_clint);

	assign ifu_rvalid = (state == st_ifu_reply);
	assign ifu_rdata  = reply_data[`IDATA_W-1:0];
	assign ifu_rresp  = reply_resp;
	assign lsu_rvalid = (state == st_lsu_reply);
	assign lsu_rdata  = reply_data;
	assign lsu_rresp  = reply_resp;

	// writes go straight to the SoC.
	assign soc_awaddr  = lsu_awaddr;
	assign soc_awsize  = lsu_awsize;
	assign soc_awvalid = lsu_awvalid;
	assign lsu_awready = soc_awready;
	assign soc_wdata   = lsu_wdata;
	assign soc_wstrb   = lsu_wstrb;
	assign soc_wvalid  = lsu_wvalid;
	assign lsu_wready  = soc_wready;
	assign lsu_bresp   = soc_bresp;
	assign lsu_bvalid  = soc_bvalid;
	assign soc_bready  = lsu_bready;

	a_reply_stable: assert property (
		@(posedge clock) disable iff (reset)
		((ifu_rvalid && !ifu_rready) || (lsu_rvalid && !lsu_rready))
		|=> ($stable(reply_data) && $stable(reply_resp))
	);

	// a line is written only with a word the SoC returned okay.
	a_fill_after_okay: assert property (
		@(posedge clock) disable iff (reset)
		cache_fill_valid |-> $past(soc_r_fire && soc_rresp == resp_okay)
	);

endmodule

//--- hw/icache.sv
`timescale 1ns/1ns
`include "mem_consts.svh"

module icache (
	input  logic                clock,
	input  logic                reset,
	input  logic [`ADDR_W-1:0]  rd_addr,
	input  logic                rd_valid,
	output logic                rd_resp_valid,
	output logic                rd_hit,
	output logic [`IDATA_W-1:0] rd_data,
	input  logic [`ADDR_W-1:0]  fill_addr,
	input  logic [`IDATA_W-1:0] fill_data,
	input  logic                fill_valid
);

	localparam int idx_w = $clog2(`ICACHE_SETS);
	localparam int tag_w = `ADDR_W - idx_w - `ICACHE_OFF_W;

	logic [`ICACHE_SETS-1:0] line_valid;
	logic [tag_w-1:0]        line_tag [`ICACHE_SETS];
	logic [`IDATA_W-1:0]     line_data [`ICACHE_SETS];

	logic [idx_w-1:0] rd_idx;
	logic [tag_w-1:0] rd_tag;
	logic [idx_w-1:0] fill_idx;
	logic [tag_w-1:0] fill_tag;

	// the index sits just above the byte offset, the tag takes the rest.
	assign rd_idx   = rd_addr[`ICACHE_OFF_W +: idx_w];
	assign rd_tag   = rd_addr[`ADDR_W-1 -: tag_w];
	assign fill_idx = fill_addr[`ICACHE_OFF_W +: idx_w];
	assign fill_tag = fill_addr[`ADDR_W-1 -: tag_w];

	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid    <= '0;
			rd_resp_valid <= 1'b0;
		end else begin
			rd_resp_valid <= rd_valid;
			if (fill_valid) begin
				line_valid[fill_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (fill_valid) begin
			line_tag[fill_idx]  <= fill_tag;
			line_data[fill_idx] <= fill_data;
		end
	end

	// lookup result is registered and shows up one cycle after rd_valid.
	always_ff @(posedge clock) begin
		if (rd_valid) begin
			rd_hit  <= line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);
			rd_data <= line_data[rd_idx];
		end
	end

	// the crossbar looks up and fills from different states.
	a_no_rd_and_fill: assert property (
		@(posedge clock) disable iff (reset)
		!(rd_valid && fill_valid)
	);

endmodule

//--- hw/clint.sv
`timescale 1ns/1ns
`include "mem_consts.svh"

module clint (
	input  logic                clock,
	input  logic                reset,
	input  logic [`ADDR_W-1:0]  araddr,
	input  logic                arvalid,
	output logic                rvalid,
	output logic [`IDATA_W-1:0] rdata,
	output mem_pkg::resp_t      rresp
);

	import mem_pkg::*;

	logic [2*`IDATA_W-1:0] mtime;
	logic [`ADDR_W-1:0]    offset;

	assign offset = araddr - `CLINT_BASE;

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime  <= '0;
			rvalid <= 1'b0;
		end else begin
			mtime  <= mtime + 1'b1;
			rvalid <= arvalid;
		end
	end

	// mtime is read as two words, low half at offset 0.
	always_ff @(posedge clock) begin
		if (arvalid) begin
			case (offset)
				`CLINT_MTIME_LO: begin
					rdata <= mtime[`IDATA_W-1:0];
					rresp <= resp_okay;
				end
				`CLINT_MTIME_HI: begin
					rdata <= mtime[2*`IDATA_W-1:`IDATA_W];
					rresp <= resp_okay;
				end
				default: begin
					rdata <= '0;
					rresp <= resp_decerr;
				end
			endcase
		end
	end

endmodule

//--- hw/mem_pkg.sv
package mem_pkg;

	// response codes, encoded as on the SoC bus.
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_exokay = 2'b01,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} resp_t;

	// read path of the crossbar.
	// the writes do not pass through this machine.
	typedef enum logic [2:0] {
		st_idle,
		st_ifu_cache,
		st_ifu_soc,
		st_cache_fill,
		st_ifu_reply,
		st_lsu_read,
		st_lsu_reply
	} xbar_state_t;

endpackage

//--- hw/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// address windows, both bounds inclusive.
`define SRAM_BASE   32'h0f00_0000
`define SRAM_LIMIT  32'h0f00_1fff
`define CLINT_BASE  32'h0200_0000
`define CLINT_LIMIT 32'h0200_ffff

// mtime offsets inside the CLINT window.
`define CLINT_MTIME_LO 32'h0000_0000
`define CLINT_MTIME_HI 32'h0000_0004

// instruction cache geometry, one 32-bit word per line.
`define ICACHE_SETS  16
`define ICACHE_OFF_W 2

`define ADDR_W  32
`define IDATA_W 32
`define DATA_W  64
`define STRB_W  8
`define SIZE_W  3

// a fetch always asks the SoC for 4 bytes.
`define FETCH_SIZE 3'd2

`endif
